//--- hw/vram_pkg.sv
/* video memory subsystem package
   frame-buffer widths, shared vector types and the host register map */

package vram_pkg;

   // data path widths
   localparam int VRAM_WORD_W = 32;
   localparam int VRAM_ADDR_W = 15;
   localparam int HOST_ADDR_W = 16;
   localparam int REG_SEL_W   = 2;
   localparam int COUNT_W     = 16;

   // one frame-buffer word, shifted out msb first
   typedef logic [VRAM_WORD_W-1:0] vram_word_t;

   // word address into the frame buffer
   typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;

   // host bus address, top bit selects register space
   typedef logic [HOST_ADDR_W-1:0] host_addr_t;

   typedef logic [REG_SEL_W-1:0] reg_sel_t;   // register index
   typedef logic [COUNT_W-1:0] count_t;       // line and word counts

   localparam int HOST_REG_BIT = HOST_ADDR_W - 1;

   // register map
   localparam reg_sel_t REG_BASE  = 2'd0;   // frame base word address
   localparam reg_sel_t REG_WORDS = 2'd1;   // words per line
   localparam reg_sel_t REG_LINES = 2'd2;   // lines per frame
   localparam reg_sel_t REG_CTRL  = 2'd3;   // enable and invert

   // control register bits
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_INVERT_BIT = 1;

   // 21k words of 32 bits
   localparam int VRAM_DEPTH_DEFAULT = 21504;

endpackage

//--- hw/vram_ifs.sv
/* frame-buffer memory port and host register bus
   each with a master side and a target side */

interface mem_port_if;
   import vram_pkg::*;

   logic en;
   logic we;
   vram_addr_t addr;
   vram_word_t wdata;
   vram_word_t rdata;   // registered, one cycle after en

   modport master (output en, we, addr, wdata, input rdata);
   modport ram (input en, we, addr, wdata, output rdata);
endinterface

interface reg_bus_if;
   import vram_pkg::*;

   logic we;
   reg_sel_t sel;
   vram_word_t wdata;
   vram_word_t rdata;   // combinational readback

   modport master (output we, sel, wdata, input rdata);
   modport slave (input we, sel, wdata, output rdata);
endinterface

//--- hw/vram_dpram.sv
/* frame-buffer RAM, true dual port with synchronous reads
   writes return the written word, out-of-range accesses read zero */

module vram_dpram #(
   parameter int RAM_SIZE = vram_pkg::VRAM_DEPTH_DEFAULT
) (
   input logic clk_a,
   input logic reset,
   mem_port_if.ram port_a,
   mem_port_if.ram port_b
);
   import vram_pkg::*;

   vram_word_t mem [RAM_SIZE];
   logic in_range_a;
   logic in_range_b;

   assign in_range_a = int'(port_a.addr) < RAM_SIZE;
   assign in_range_b = int'(port_b.addr) < RAM_SIZE;

   // storage, port b wins if both write one word
   always_ff @(posedge clk_a)
   begin
      if (port_a.en && port_a.we && in_range_a)
         mem[port_a.addr] <= port_a.wdata;
      if (port_b.en && port_b.we && in_range_b)
         mem[port_b.addr] <= port_b.wdata;
   end

   // read registers hold their value while en is low
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         port_a.rdata <= '0;
         port_b.rdata <= '0;
      end
      else
      begin
         if (port_a.en)
         begin
            if (!in_range_a)
               port_a.rdata <= '0;
            else if (port_a.we)
               port_a.rdata <= port_a.wdata;   // write-through
            else
               port_a.rdata <= mem[port_a.addr];   // old word on collision
         end
         if (port_b.en)
         begin
            if (!in_range_b)
               port_b.rdata <= '0;
            else if (port_b.we)
               port_b.rdata <= port_b.wdata;
            else
               port_b.rdata <= mem[port_b.addr];
         end
      end
   end

endmodule

//--- hw/vram_host_port.sv
/* host slave for the four-phase req/ack bus
   routes each request to the frame buffer or the register set */

module vram_host_port (
   input logic clk_a,
   input logic reset,
   input logic host_req,
   input logic host_we,
   input vram_pkg::host_addr_t host_addr,
   input vram_pkg::vram_word_t host_wdata,
   output logic host_ack,
   output vram_pkg::vram_word_t host_rdata,
   mem_port_if.master mem,
   reg_bus_if.master regs
);
   import vram_pkg::*;

   typedef enum logic [1:0] {
      idle,
      ram_wait,   // RAM read data on its way
      reg_done,   // first ack cycle of a register access
      ack_hold    // ack up until req drops
   } host_state_t;

   host_state_t state;
   logic start;
   logic reg_space;

   assign reg_space = host_addr[HOST_REG_BIT];
   assign start = (state == idle) && host_req;

   // one strobe per request, issued in the cycle req is first seen
   assign mem.en = start && !reg_space;
   assign mem.we = host_we;
   assign mem.addr = host_addr[VRAM_ADDR_W-1:0];
   assign mem.wdata = host_wdata;

   assign regs.we = start && reg_space && host_we;
   assign regs.sel = host_addr[REG_SEL_W-1:0];
   assign regs.wdata = host_wdata;

   assign host_ack = (state == reg_done) || (state == ack_hold);

   always_ff @(posedge clk_a)
   begin
      if (reset)
         state <= idle;
      else
      begin
         case (state)
            idle:
               if (host_req)
                  state <= reg_space ? reg_done : ram_wait;
            ram_wait:
               state <= ack_hold;
            reg_done:
            begin
               if (!host_req)
                  state <= idle;   // req already gone
               else
                  state <= ack_hold;
            end
            default:
               if (!host_req)
                  state <= idle;
         endcase
      end
   end

   // read data settles before ack goes up
   always_ff @(posedge clk_a)
   begin
      if (start && reg_space)
         host_rdata <= regs.rdata;
      else if (state == ram_wait)
         host_rdata <= mem.rdata;   // written word on a write
   end

endmodule

//--- hw/vram_regs.sv
/* display configuration registers
   frame base, line geometry and the enable and invert controls */

module vram_regs (
   input logic clk_a,
   input logic reset,
   reg_bus_if.slave bus,
   output vram_pkg::vram_addr_t base,
   output vram_pkg::count_t words_per_line,
   output vram_pkg::count_t lines,
   output logic enable,
   output logic invert
);
   import vram_pkg::*;

   logic [1:0] ctrl_q;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         base <= '0;
         words_per_line <= '0;
         lines <= '0;
         ctrl_q <= '0;   // scanout off
      end
      else if (bus.we)
      begin
         case (bus.sel)
            REG_BASE:
               base <= bus.wdata[VRAM_ADDR_W-1:0];
            REG_WORDS:
               words_per_line <= bus.wdata[COUNT_W-1:0];
            REG_LINES:
               lines <= bus.wdata[COUNT_W-1:0];
            default:
            begin
               ctrl_q[CTRL_ENABLE_BIT] <= bus.wdata[CTRL_ENABLE_BIT];
               ctrl_q[CTRL_INVERT_BIT] <= bus.wdata[CTRL_INVERT_BIT];
            end
         endcase
      end
   end

   // readback, unused upper bits are zero
   always_comb
   begin
      case (bus.sel)
         REG_BASE:
            bus.rdata = vram_word_t'(base);
         REG_WORDS:
            bus.rdata = vram_word_t'(words_per_line);
         REG_LINES:
            bus.rdata = vram_word_t'(lines);
         default:
            bus.rdata = vram_word_t'(ctrl_q);
      endcase
   end

   assign enable = ctrl_q[CTRL_ENABLE_BIT];
   assign invert = ctrl_q[CTRL_INVERT_BIT];

endmodule

//--- hw/vram_scanout.sv
/* scanout engine, walks the frame buffer word by word
   and shifts each word out as one pixel per clock, msb first */

module vram_scanout (
   input logic clk_a,
   input logic reset,
   mem_port_if.master mem,
   input vram_pkg::vram_addr_t base,
   input vram_pkg::count_t words_per_line,
   input vram_pkg::count_t lines,
   input logic enable,
   input logic invert,
   output logic pixel,
   output logic pixel_valid,
   output logic frame_start
);
   import vram_pkg::*;

   localparam int BIT_W = $clog2(VRAM_WORD_W);

   typedef enum logic [1:0] {idle, prime, run} scan_state_t;

   scan_state_t state;
   logic [2*COUNT_W-1:0] frame_len;
   logic [2*COUNT_W-1:0] fetch_left;   // words still to fetch in this frame
   vram_addr_t fetch_addr;
   logic cfg_valid;
   logic cfg_ok;        // geometry of the frame being fetched
   logic fetch_first;   // next fetch opens a frame
   logic next_first;    // tags of the word waiting in the RAM output
   logic next_stop;
   vram_word_t shift_q;
   logic [BIT_W-1:0] bit_cnt;
   logic inv_q;
   logic load;
   logic stop;
   logic fetch;

   assign frame_len = words_per_line * lines;
   assign cfg_valid = (words_per_line != '0) && (lines != '0);

   // the RAM output register holds the prefetched word
   assign load = (state == run) && (!pixel_valid || bit_cnt == BIT_W'(VRAM_WORD_W - 1));
   assign stop = !enable || next_stop;
   assign fetch = (state == prime) || (load && !stop);

   assign mem.en = fetch;
   assign mem.we = 1'b0;   // read only
   assign mem.addr = fetch_addr;
   assign mem.wdata = '0;

   assign pixel = pixel_valid & (shift_q[VRAM_WORD_W-1] ^ inv_q);

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= idle;
         pixel_valid <= 1'b0;
         frame_start <= 1'b0;
         bit_cnt <= '0;
         inv_q <= 1'b0;
      end
      else
      begin
         frame_start <= 1'b0;
         case (state)
            idle:
               if (enable && cfg_valid)
                  state <= prime;
            prime:
               state <= run;
            default:
            begin
               if (load && stop)
               begin
                  state <= idle;   // ends on a word boundary
                  pixel_valid <= 1'b0;
               end
               else if (load)
               begin
                  pixel_valid <= 1'b1;
                  frame_start <= next_first;
                  bit_cnt <= '0;
                  if (next_first)
                     inv_q <= invert;   // invert taken per frame
               end
               else
                  bit_cnt <= bit_cnt + 1'b1;
            end
         endcase
      end
   end

   // fetch pointer, config sampled when a frame wraps
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         fetch_addr <= '0;
         fetch_left <= '0;
         fetch_first <= 1'b0;
         cfg_ok <= 1'b0;
         next_first <= 1'b0;
         next_stop <= 1'b0;
      end
      else if (state == idle)
      begin
         fetch_addr <= base;
         fetch_left <= frame_len;
         fetch_first <= 1'b1;
         cfg_ok <= cfg_valid;
      end
      else if (fetch)
      begin
         next_first <= fetch_first;
         next_stop <= fetch_first && !cfg_ok;   // zero-sized frame
         if (fetch_left == 1)
         begin
            fetch_addr <= base;
            fetch_left <= frame_len;
            fetch_first <= 1'b1;
            cfg_ok <= cfg_valid;
         end
         else
         begin
            fetch_addr <= fetch_addr + 1'b1;
            fetch_left <= fetch_left - 1'b1;
            fetch_first <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (load)
         shift_q <= mem.rdata;
      else
         shift_q <= shift_q << 1;
   end

endmodule

//--- hw/vram_top.sv
/* video memory subsystem top level
   host port, config registers, scanout and the frame-buffer RAM */

module vram_top #(
   parameter int RAM_SIZE = vram_pkg::VRAM_DEPTH_DEFAULT
) (
   input logic clk_a,
   input logic reset,
   input logic host_req,
   input logic host_we,
   input vram_pkg::host_addr_t host_addr,
   input vram_pkg::vram_word_t host_wdata,
   output logic host_ack,
   output vram_pkg::vram_word_t host_rdata,
   output logic pixel,
   output logic pixel_valid,
   output logic frame_start
);
   import vram_pkg::*;

   vram_addr_t base;
   count_t words_per_line;
   count_t lines;
   logic enable;
   logic invert;

   mem_port_if mem_a ();   // host side
   mem_port_if mem_b ();   // scanout side
   reg_bus_if reg_bus ();

   vram_dpram #(
      .RAM_SIZE(RAM_SIZE)
   ) i_dpram (
      .clk_a(clk_a),
      .reset(reset),
      .port_a(mem_a.ram),
      .port_b(mem_b.ram)
   );

   vram_host_port i_host_port (
      .clk_a(clk_a),
      .reset(reset),
      .host_req(host_req),
      .host_we(host_we),
      .host_addr(host_addr),
      .host_wdata(host_wdata),
      .host_ack(host_ack),
      .host_rdata(host_rdata),
      .mem(mem_a.master),
      .regs(reg_bus.master)
   );

   vram_regs i_regs (
      .clk_a(clk_a),
      .reset(reset),
      .bus(reg_bus.slave),
      .base(base),
      .words_per_line(words_per_line),
      .lines(lines),
      .enable(enable),
      .invert(invert)
   );

   vram_scanout i_scanout (
      .clk_a(clk_a),
      .reset(reset),
      .mem(mem_b.master),
      .base(base),
      .words_per_line(words_per_line),
      .lines(lines),
      .enable(enable),
      .invert(invert),
      .pixel(pixel),
      .pixel_valid(pixel_valid),
      .frame_start(frame_start)
   );

endmodule

//--- verif/vram_tb.sv
/* testbench for the video memory subsystem
   host accesses from a table against a reference model, pixel stream checked per frame */

module vram_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import vram_pkg::*;

   localparam int RAM_SIZE = VRAM_DEPTH_DEFAULT;
   localparam int FRAME_BASE = 200;
   localparam int FRAME_WORDS = 3;
   localparam int FRAME_LINES = 2;
   localparam int FRAME_PIX = FRAME_WORDS * FRAME_LINES * VRAM_WORD_W;
   localparam int HS_LIMIT = 20;   // cycles per handshake phase

   typedef enum {op_write, op_read, op_reg_write, op_reg_read, op_frames} op_kind_t;

   typedef struct {
      op_kind_t kind;
      host_addr_t addr;
      vram_word_t data;   // frame count for op_frames
      vram_word_t exp;
   } op_t;

   logic clk_a;
   logic reset;
   logic host_req;
   logic host_we;
   host_addr_t host_addr;
   vram_word_t host_wdata;
   logic host_ack;
   vram_word_t host_rdata;
   logic pixel;
   logic pixel_valid;
   logic frame_start;

   op_t ops[$];
   vram_word_t ref_mem [RAM_SIZE];
   vram_word_t ref_reg [4];
   int word_errs = 0;
   int pixel_errs = 0;
   int reg_errs = 0;
   int other_errs = 0;
   int limit_cycles = 0;
   logic ack_q;

   vram_top i_dut (
      .clk_a(clk_a),
      .reset(reset),
      .host_req(host_req),
      .host_we(host_we),
      .host_addr(host_addr),
      .host_wdata(host_wdata),
      .host_ack(host_ack),
      .host_rdata(host_rdata),
      .pixel(pixel),
      .pixel_valid(pixel_valid),
      .frame_start(frame_start)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #10 clk_a = ~clk_a;
   end

   // four-phase ordering of ack against req
   always @(posedge clk_a)
   begin
      if (!reset && host_ack && !ack_q && !host_req)
      begin
         $display("host_ack rose at %0t with no host_req pending", $time);
         other_errs++;
      end
      if (!reset && !host_ack && ack_q && host_req)
      begin
         $display("host_ack fell at %0t while host_req was still high", $time);
         other_errs++;
      end
      ack_q <= host_ack;
   end

   task automatic check_word(input string name, input vram_word_t got, input vram_word_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         word_errs++;
      end
   endtask

   task automatic check_pixel(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         pixel_errs++;
      end
   endtask

   task automatic check_reg(input string name, input count_t got, input count_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         reg_errs++;
      end
   endtask

   function automatic vram_word_t reg_mask(input reg_sel_t sel);
      case (sel)
         REG_BASE: return vram_word_t'((1 << VRAM_ADDR_W) - 1);
         REG_CTRL: return 32'h3;   // enable and invert only
         default: return vram_word_t'((1 << COUNT_W) - 1);
      endcase
   endfunction

   function automatic host_addr_t reg_addr(input reg_sel_t sel);
      return host_addr_t'(1 << HOST_REG_BIT) | host_addr_t'(sel);
   endfunction

   // expected read, the last word written to that address
   function automatic vram_word_t last_written(input logic reg_space, input host_addr_t addr);
      op_kind_t wr_kind;
      wr_kind = reg_space ? op_reg_write : op_write;
      if (!reg_space && int'(addr) >= RAM_SIZE)
         return '0;   // out of range reads zero
      for (int i = ops.size() - 1; i >= 0; i--)
         if (ops[i].kind == wr_kind && ops[i].addr == addr)
            return reg_space ? ops[i].data & reg_mask(reg_sel_t'(addr)) : ops[i].data;
      return '0;   // reset value
   endfunction

   function automatic void add_op(input op_kind_t kind, input host_addr_t addr,
                                  input vram_word_t data);
      op_t op;
      op.kind = kind;
      op.addr = addr;
      op.data = data;
      op.exp = '0;
      if (kind == op_read || kind == op_reg_read)
         op.exp = last_written(kind == op_reg_read, addr);
      ops.push_back(op);
   endfunction

   function automatic void build_ops();
      int addrs [$] = '{0, 1, 1789, 5366, 10000, 15001, 21502, 21503};
      foreach (addrs[i])
         add_op(op_write, host_addr_t'(addrs[i]), $urandom());
      add_op(op_write, 16'd1789, $urandom());   // overwrite
      foreach (addrs[i])
         add_op(op_read, host_addr_t'(addrs[i]), '0);
      add_op(op_write, 16'd21504, $urandom());   // first word past the end
      add_op(op_write, 16'h7fff, $urandom());
      add_op(op_read, 16'd21504, '0);
      add_op(op_read, 16'h7fff, '0);
      add_op(op_read, 16'd21503, '0);
      add_op(op_read, 16'd21502, '0);
      for (int s = 0; s < 3; s++)
         add_op(op_reg_write, reg_addr(reg_sel_t'(s)), '1);
      add_op(op_reg_write, reg_addr(REG_CTRL), 32'hffff_fffc);   // enable stays off
      for (int s = 0; s < 4; s++)
         add_op(op_reg_read, reg_addr(reg_sel_t'(s)), '0);
      add_op(op_reg_write, reg_addr(REG_BASE), FRAME_BASE);
      add_op(op_reg_write, reg_addr(REG_WORDS), FRAME_WORDS);
      add_op(op_reg_write, reg_addr(REG_LINES), FRAME_LINES);
      for (int s = 0; s < 3; s++)
         add_op(op_reg_read, reg_addr(reg_sel_t'(s)), '0);
      for (int k = 0; k < FRAME_WORDS * FRAME_LINES; k++)
         add_op(op_write, host_addr_t'(FRAME_BASE + k), $urandom());
      add_op(op_reg_write, reg_addr(REG_CTRL), 32'h1);
      add_op(op_frames, '0, 2);
      add_op(op_reg_write, reg_addr(REG_CTRL), 32'h3);   // invert
      add_op(op_reg_read, reg_addr(REG_CTRL), '0);
      add_op(op_frames, '0, 1);
      add_op(op_write, host_addr_t'(FRAME_BASE + 1), $urandom());   // while running
      add_op(op_write, host_addr_t'(FRAME_BASE + 4), $urandom());
      add_op(op_frames, '0, 1);
      add_op(op_reg_write, reg_addr(REG_CTRL), 32'h0);
      add_op(op_frames, '0, 1);
   endfunction

   task automatic host_access(input logic we, input host_addr_t addr, input vram_word_t data,
                              output vram_word_t rdata);
      int n;
      host_req <= 1'b1;
      host_we <= we;
      host_addr <= addr;
      host_wdata <= data;
      n = 0;
      @(posedge clk_a);
      while (!host_ack && n < HS_LIMIT)
      begin
         @(posedge clk_a);
         n++;
      end
      if (!host_ack)
      begin
         $display("no host_ack at %0t for the access to address %h", $time, addr);
         other_errs++;
      end
      rdata = host_rdata;   // valid while ack is high
      host_req <= 1'b0;
      n = 0;
      @(posedge clk_a);
      while (host_ack && n < HS_LIMIT)
      begin
         @(posedge clk_a);
         n++;
      end
      if (host_ack)
      begin
         $display("host_ack still high at %0t after host_req fell", $time);
         other_errs++;
      end
   endtask

   task automatic wait_frame_start(input int limit, output bit found);
      int n;
      n = 0;
      @(posedge clk_a);
      while (!frame_start && n < limit)
      begin
         @(posedge clk_a);
         n++;
      end
      found = frame_start;
      if (!found)
      begin
         $display("no frame_start seen within %0d cycles at %0t", limit, $time);
         other_errs++;
      end
   endtask

   task automatic check_frames(input int n);
      int fp;
      int cnt;
      bit found;
      vram_word_t w;
      logic exp_bit;
      fp = int'(ref_reg[REG_WORDS]) * int'(ref_reg[REG_LINES]) * VRAM_WORD_W;
      if (!ref_reg[REG_CTRL][CTRL_ENABLE_BIT])
      begin
         cnt = 0;
         while (pixel_valid && cnt < VRAM_WORD_W)   // rest of the current word
         begin
            @(posedge clk_a);
            cnt++;
         end
         if (pixel_valid)
         begin
            $display("pixel_valid still high at %0t after enable was cleared", $time);
            other_errs++;
         end
         for (int i = 0; i < n * fp; i++)
         begin
            @(posedge clk_a);
            check_pixel("pixel_valid", pixel_valid, 1'b0);
         end
         return;
      end
      // frame in flight may predate the last host write
      wait_frame_start(2 * fp + 100, found);
      if (found)
         wait_frame_start(2 * fp + 100, found);
      if (!found)
         return;
      for (int i = 0; i < n * fp; i++)
      begin
         if (i > 0)
            @(posedge clk_a);
         w = ref_mem[int'(ref_reg[REG_BASE]) + (i / VRAM_WORD_W) % (fp / VRAM_WORD_W)];
         exp_bit = w[VRAM_WORD_W - 1 - i % VRAM_WORD_W] ^ ref_reg[REG_CTRL][CTRL_INVERT_BIT];
         check_pixel("pixel_valid", pixel_valid, 1'b1);
         check_pixel("frame_start", frame_start, (i % fp) == 0);
         check_pixel("pixel", pixel, exp_bit);
      end
   endtask

   task automatic apply_op(input op_t op);
      vram_word_t rdata;
      case (op.kind)
         op_write:
         begin
            host_access(1'b1, op.addr, op.data, rdata);
            if (int'(op.addr) < RAM_SIZE)
               ref_mem[int'(op.addr)] = op.data;
         end
         op_reg_write:
         begin
            host_access(1'b1, op.addr, op.data, rdata);
            ref_reg[reg_sel_t'(op.addr)] = op.data & reg_mask(reg_sel_t'(op.addr));
         end
         op_read:
         begin
            host_access(1'b0, op.addr, '0, rdata);
            check_word($sformatf("host_rdata @%h", op.addr), rdata, op.exp);
         end
         op_reg_read:
         begin
            host_access(1'b0, op.addr, '0, rdata);
            check_reg($sformatf("reg %0d low half", op.addr[1:0]), rdata[15:0], op.exp[15:0]);
            check_reg($sformatf("reg %0d high half", op.addr[1:0]), rdata[31:16], op.exp[31:16]);
         end
         default:
            check_frames(int'(op.data));
      endcase
   endtask

   initial
   begin
      int frames;
      void'($urandom(32'hcfd));
      reset <= 1'b1;
      host_req <= 1'b0;
      host_we <= 1'b0;
      host_addr <= '0;
      host_wdata <= '0;
      foreach (ref_reg[i])
         ref_reg[i] = '0;
      build_ops();
      frames = 0;
      foreach (ops[i])
         if (ops[i].kind == op_frames)
            frames += int'(ops[i].data) + 2;   // plus skipped and partial frames
      limit_cycles = ops.size() * 40 + (frames + 3) * FRAME_PIX;
      repeat (2) @(posedge clk_a);
      reset <= 1'b0;
      foreach (ops[i])
         apply_op(ops[i]);
      $display("word errors %0d, pixel errors %0d, register errors %0d, other errors %0d",
               word_errs, pixel_errs, reg_errs, other_errs);
      if (word_errs + pixel_errs + reg_errs + other_errs == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // watchdog
   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk_a);
      $display("watchdog expired after %0d cycles, the test did not finish", limit_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- sources.f
hw/vram_pkg.sv
hw/vram_ifs.sv
hw/vram_dpram.sv
hw/vram_host_port.sv
hw/vram_regs.sv
hw/vram_scanout.sv
hw/vram_top.sv
verif/vram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the video memory testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module vram_tb -f sources.f -o vram_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/vram_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
   echo "simulation failed, see $log"
   exit 1
fi

echo "simulation passed"
exit 0
